// ==== flist.f ====
src/dac_cfg_pkg.sv
src/cmd_pkg.sv
src/dac_serial_bank.sv
src/ldac_pulse_gen.sv
src/dac_cmd_controller.sv
src/dac_board_top.sv
tests/tb_dac_board_assert.sv
tests/tb_dac_board.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dac_board -f flist.f -o sim_tb \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; } || \
    { grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" || \
    { echo "Simulation ended without a result"; exit 1; }; }

// ==== tests/tb_dac_board.sv ====
`timescale 1ns/1ps

module tb_dac_board;
    import dac_cfg_pkg::*;
    import cmd_pkg::*;

    localparam int NUM_CH       = 8;
    localparam int RESET_CYCLES = 16;
    // Commands sent over the whole run, for the watchdog
    localparam int NUM_CMDS     = 40;

    logic                      CLK100MHZ;
    logic                      rst_n;
    cmd_t                      cmd;
    logic                      cmd_ready;
    reply_t                    reply;
    dac_pins_t [NUM_CH-1:0]    dac_pins;
    logic                      ldac_n;

    integer      seed;
    string       test_name;
    // Handed from stimulus to the compare process
    logic [7:0]  cur_hits;
    logic [23:0] cur_word;
    event        compare_ev;
    // Frame monitor results per channel
    int          frame_cnt [NUM_CH];
    logic [23:0] frame_word [NUM_CH];
    // LDAC pin monitor
    int          ldac_run;
    int          ldac_width;
    int          ldac_pulses;
    int          ldac_len_model;

    dac_board_top #(
        .NUM_CHANNELS (NUM_CH)
    ) u_dut (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .reply     (reply),
        .dac_pins  (dac_pins),
        .ldac_n    (ldac_n)
    );

    always #5 CLK100MHZ = ~CLK100MHZ;

    ////////////////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Which channels see a frame, and the word they get
    function automatic logic [7:0] expected_frames(input logic [3:0] op, input logic [7:0] len,
                                                   input logic [31:0] payload,
                                                   output logic [23:0] word);
        word = payload[23:0];
        if (op == 4'h1 && len == 8'd4) begin
            return payload[31:24];
        end
        if (op == 4'h2) begin
            word = 24'h004000;
            return payload[31:24];
        end
        return 8'h00;
    endfunction

    // Reply as {valid, code, arg}
    function automatic logic [10:0] expected_reply(input logic [3:0] op, input logic [7:0] len);
        if (op == 4'h1 && len != 8'd4) begin
            return {1'b1, 2'd1, len};
        end
        if (op == 4'h0 || op > 4'h4) begin
            return {1'b1, 2'd2, 8'd0};
        end
        return 11'd0;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_CH; i++) begin : g_mon
        logic [23:0] shift;
        int          bits = 0;
        int          cnt  = 0;

        // Any chip select pulse counts as a frame
        always @(negedge dac_pins[i].cs_n) begin
            bits = 0;
            cnt++;
        end

        // DAC samples sdi on the rising sclk
        always @(posedge dac_pins[i].sclk) begin
            if (!dac_pins[i].cs_n) begin
                shift = {shift[22:0], dac_pins[i].sdi};
                bits++;
            end
        end

        always @(posedge dac_pins[i].cs_n) begin
            if (rst_n) begin
                check("frame bit count", 32'd24, bits);
                bits = 0;
            end
        end

        assign frame_cnt[i]  = cnt;
        assign frame_word[i] = shift;
    end

    // Low width of the load strobe in clock cycles
    always @(posedge CLK100MHZ) begin
        if (rst_n) begin
            if (!ldac_n) begin
                ldac_run++;
            end else if (ldac_run != 0) begin
                ldac_width = ldac_run;
                ldac_run   = 0;
                ldac_pulses++;
            end
        end
    end

    // Compare process, expected counts kept here
    always @(compare_ev) begin
        int exp_cnt [NUM_CH];
        for (int ch = 0; ch < NUM_CH; ch++) begin
            exp_cnt[ch] += int'(cur_hits[ch]);
            check({test_name, " frame count"}, exp_cnt[ch], frame_cnt[ch]);
            if (cur_hits[ch]) begin
                check({test_name, " frame word"}, {8'h00, cur_word}, {8'h00, frame_word[ch]});
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////

    // Called and returns at 1 ns after a rising edge
    task automatic wait_ready();
        while (!cmd_ready) begin
            @(posedge CLK100MHZ);
            #1;
        end
    endtask

    task automatic send_cmd(input logic [3:0] op, input logic [7:0] len,
                            input logic [31:0] payload);
        wait_ready();
        cmd = '{valid: 1'b1, opcode: opcode_e'(op), length: len, payload: payload};
        @(posedge CLK100MHZ);
        #1;
        cmd.valid = 1'b0;
    endtask

    // Full command with reply and frame checks
    task automatic run_cmd(input logic [3:0] op, input logic [7:0] len,
                           input logic [31:0] payload);
        logic [10:0] exp_rpl;
        logic [23:0] word;
        logic [7:0]  hits;
        exp_rpl = expected_reply(op, len);
        hits    = expected_frames(op, len, payload, word);
        send_cmd(op, len, payload);
        if (exp_rpl[10]) begin
            check({test_name, " reply"}, {21'd0, exp_rpl}, {21'd0, reply});
        end else begin
            check({test_name, " reply valid"}, 32'd0, {31'd0, reply.valid});
        end
        // Nothing to do, so the controller stays idle
        if (!exp_rpl[10] && hits == 8'h00 && op != 4'h3) begin
            check({test_name, " ready held"}, 32'd1, {31'd0, cmd_ready});
        end
        if (op == 4'h4) begin
            ldac_len_model = int'(payload[7:0]);
        end
        wait_ready();
        cur_hits = hits;
        cur_word = word;
        -> compare_ev;
        @(posedge CLK100MHZ);
        #1;
    endtask

    task automatic run_ldac();
        int pulses;
        pulses = ldac_pulses;
        run_cmd(4'h3, 8'd0, 32'd0);
        check({test_name, " ldac pulses"}, pulses + 1, ldac_pulses);
        check({test_name, " ldac width"}, ldac_len_model + 2, ldac_width);
    endtask

    initial begin
        logic [7:0]  mask;
        logic [7:0]  len;
        logic [23:0] data;
        int          pulses;
        seed           = 8684;
        CLK100MHZ      = 1'b0;
        rst_n          = 1'b0;
        cmd            = '0;
        cur_hits       = '0;
        cur_word       = '0;
        ldac_run       = 0;
        ldac_width     = 0;
        ldac_pulses    = 0;
        ldac_len_model = 40;
        repeat (RESET_CYCLES) @(posedge CLK100MHZ);
        #1;
        rst_n = 1'b1;
        @(posedge CLK100MHZ);
        #1;

        // LDAC width right after reset
        test_name = "ldac default";
        run_ldac();

        test_name = "write reg";
        for (int n = 0; n < 20; n++) begin
            mask = 8'($random(seed));
            data = 24'($random(seed));
            run_cmd(4'h1, 8'd4, {mask, data});
        end

        test_name = "ld";
        for (int n = 0; n < 6; n++) begin
            mask = 8'($random(seed));
            if (mask == 8'h00) begin
                mask = 8'h01;
            end
            data = 24'($random(seed));
            run_cmd(4'h2, 8'd3, {mask, data});
        end
        test_name = "ld zero mask";
        run_cmd(4'h2, 8'd4, 32'h00ABCDEF);

        // Lengths other than 4
        test_name = "wrong length";
        for (int n = 0; n < 4; n++) begin
            len = 8'($random(seed));
            if (len == 8'd4) begin
                len = 8'd5;
            end
            run_cmd(4'h1, len, 32'hFF123456);
        end

        test_name = "ldac length";
        len = 8'($random(seed));
        run_cmd(4'h4, 8'd1, {24'd0, len});
        run_ldac();

        test_name = "unknown opcode";
        run_cmd(4'h0, 8'd4, 32'hFF000000);
        run_cmd(4'h5, 8'd4, 32'hFF000000);
        run_cmd(4'h9, 8'd0, 32'h0);
        run_cmd(4'hF, 8'd2, 32'h0);

        // WRITE REG strobed while the LDAC pulse holds cmd_ready low
        test_name = "dropped command";
        pulses    = ldac_pulses;
        send_cmd(4'h3, 8'd0, 32'd0);
        @(posedge CLK100MHZ);
        #1;
        check("dropped command ready", 32'd0, {31'd0, cmd_ready});
        cmd = '{valid: 1'b1, opcode: OP_WRITE_REG, length: 8'd4, payload: 32'hFF5A5A5A};
        @(posedge CLK100MHZ);
        #1;
        cmd.valid = 1'b0;
        wait_ready();
        cur_hits = 8'h00;
        -> compare_ev;
        @(posedge CLK100MHZ);
        #1;
        check("dropped command ldac pulses", pulses + 1, ldac_pulses);
        check("dropped command ldac width", ldac_len_model + 2, ldac_width);

        $display("TEST RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_CMDS * 200 + RESET_CYCLES) * 10);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== tests/tb_dac_board_assert.sv ====
`timescale 1ns/1ps

module tb_dac_board_assert #(
    parameter int NUM_CHANNELS = 8
) (
    input logic                    CLK100MHZ,
    input logic                    rst_n,
    input logic                    reply_valid,
    input logic [1:0]              state,
    input logic                    cmd_ready,
    input logic [NUM_CHANNELS-1:0] dac_start,
    input logic [NUM_CHANNELS-1:0] dac_busy,
    input logic                    ldac_start,
    input logic                    ldac_busy
);

    // Encodings of the controller state enum
    localparam logic [1:0] ST_WAIT_BUSY_OFF = 2'd2;
    localparam logic [1:0] ST_LDAC_ACTIVE   = 2'd3;

    // Reply strobe lasts one cycle
    a_reply_pulse : assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        reply_valid |=> !reply_valid)
        else $error("reply.valid high for two cycles");

    // Start request only from idle or while waiting for busy
    a_start_state : assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        (state == ST_WAIT_BUSY_OFF || state == ST_LDAC_ACTIVE) |-> (dac_start == '0))
        else $error("dac_start high outside its states");

    a_ldac_pulse : assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        ldac_start |=> !ldac_start)
        else $error("ldac_start longer than one cycle");

    // No new command while a worker runs
    a_ready_busy : assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        ((|dac_busy) || ldac_busy) |-> !cmd_ready)
        else $error("cmd_ready high while busy");

endmodule

bind dac_cmd_controller tb_dac_board_assert #(
    .NUM_CHANNELS (NUM_CHANNELS)
) u_assert (
    .CLK100MHZ   (CLK100MHZ),
    .rst_n       (rst_n),
    .reply_valid (reply.valid),
    .state       (state),
    .cmd_ready   (cmd_ready),
    .dac_start   (dac_start),
    .dac_busy    (dac_busy),
    .ldac_start  (ldac_start),
    .ldac_busy   (ldac_busy)
);

// ==== src/dac_board_top.sv ====
`timescale 1ns/1ps

module dac_board_top #(
    parameter int NUM_CHANNELS = 8
) (
    input  logic                                      CLK100MHZ,
    input  logic                                      rst_n,
    input  cmd_pkg::cmd_t                             cmd,
    output logic                                      cmd_ready,
    output cmd_pkg::reply_t                           reply,
    output dac_cfg_pkg::dac_pins_t [NUM_CHANNELS-1:0] dac_pins,
    output logic                                      ldac_n
);
    import dac_cfg_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Controller to workers
    //////////////////////////////////////////////////////////////////////

    // Serial bank
    logic [NUM_CHANNELS-1:0] dac_start;
    logic [NUM_CHANNELS-1:0] dac_busy;
    dac_word_t               dac_word;

    // LDAC strobe
    logic                    ldac_start;
    logic [7:0]              ldac_len;
    logic                    ldac_busy;

    // Command FSM, owns the LDAC width and the replies
    dac_cmd_controller #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_ctrl (
        .CLK100MHZ  (CLK100MHZ),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .reply      (reply),
        .dac_start  (dac_start),
        .dac_word   (dac_word),
        .dac_busy   (dac_busy),
        .ldac_start (ldac_start),
        .ldac_len   (ldac_len),
        .ldac_busy  (ldac_busy)
    );

    // One frame shifter per DAC chip
    dac_serial_bank #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_bank (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .dac_start (dac_start),
        .dac_word  (dac_word),
        .dac_busy  (dac_busy),
        .dac_pins  (dac_pins)
    );

    // Shared load strobe
    ldac_pulse_gen u_ldac (
        .CLK100MHZ  (CLK100MHZ),
        .rst_n      (rst_n),
        .ldac_start (ldac_start),
        .ldac_len   (ldac_len),
        .ldac_busy  (ldac_busy),
        .ldac_n     (ldac_n)
    );

endmodule

// ==== src/dac_cmd_controller.sv ====
`timescale 1ns/1ps

module dac_cmd_controller #(
    parameter int NUM_CHANNELS = 8
) (
    input  logic                    CLK100MHZ,
    input  logic                    rst_n,
    input  cmd_pkg::cmd_t           cmd,
    output logic                    cmd_ready,
    output cmd_pkg::reply_t         reply,
    output logic [NUM_CHANNELS-1:0] dac_start,
    output dac_cfg_pkg::dac_word_t  dac_word,
    input  logic [NUM_CHANNELS-1:0] dac_busy,
    output logic                    ldac_start,
    output logic [7:0]              ldac_len,
    input  logic                    ldac_busy
);
    import dac_cfg_pkg::*;
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_BUSY_ON,
        ST_WAIT_BUSY_OFF,
        ST_LDAC_ACTIVE
    } state_e;

    state_e                  state;
    logic                    accept;
    // Full mask from the payload top byte
    logic [MASK_WIDTH-1:0]   cmd_mask;
    // Mask bits of channels that exist
    logic [NUM_CHANNELS-1:0] chan_mask;

    //////////////////////////////////////////////////////////////////////
    // Handshake and decode
    //////////////////////////////////////////////////////////////////////

    // Idle also means no reply going out this cycle
    // Keeps back-to-back errors from merging into a 2-cycle reply
    assign cmd_ready = (state == ST_IDLE) && !reply.valid;

    assign accept = cmd.valid && cmd_ready;

    assign cmd_mask  = cmd.payload[DAC_DATA_WIDTH +: MASK_WIDTH];
    // Upper mask bits dropped when fewer channels are built
    assign chan_mask = cmd_mask[NUM_CHANNELS-1:0];

    //////////////////////////////////////////////////////////////////////
    // Main FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            dac_start  <= '0;
            ldac_start <= 1'b0;
            ldac_len   <= LDAC_LEN_DEFAULT;
            reply      <= '{valid: 1'b0, code: RPL_NONE, arg: 8'd0};
        end else begin
            // Single-cycle strobes
            reply.valid <= 1'b0;
            ldac_start  <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        case (cmd.opcode)
                            OP_WRITE_REG: begin
                                // Length first, even with an empty mask
                                if (cmd.length != WRITE_REG_BYTES) begin
                                    reply <= '{valid: 1'b1,
                                               code:  RPL_WRONG_LENGTH,
                                               arg:   cmd.length};
                                end else if (chan_mask != '0) begin
                                    dac_start <= chan_mask;
                                    state     <= ST_WAIT_BUSY_ON;
                                end
                            end
                            OP_LD: begin
                                // No length check for LD
                                if (chan_mask != '0) begin
                                    dac_start <= chan_mask;
                                    state     <= ST_WAIT_BUSY_ON;
                                end
                            end
                            OP_LDAC: begin
                                ldac_start <= 1'b1;
                                state      <= ST_LDAC_ACTIVE;
                            end
                            OP_SET_LDAC_LEN: begin
                                ldac_len <= cmd.payload[7:0];
                            end
                            default: begin
                                reply <= '{valid: 1'b1,
                                           code:  RPL_UNKNOWN_CMD,
                                           arg:   8'd0};
                            end
                        endcase
                    end
                end

                // Start held until the bank reports a frame
                ST_WAIT_BUSY_ON: begin
                    if (|dac_busy) begin
                        dac_start <= '0;
                        state     <= ST_WAIT_BUSY_OFF;
                    end
                end

                // Lockstep channels, all finish together
                ST_WAIT_BUSY_OFF: begin
                    if (dac_busy == '0) begin
                        state <= ST_IDLE;
                    end
                end

                // Busy rises a cycle after the start pulse
                ST_LDAC_ACTIVE: begin
                    if (!ldac_start && !ldac_busy) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data word to the bank
    //////////////////////////////////////////////////////////////////////

    // Stable from acceptance until the controller is idle again
    always_ff @(posedge CLK100MHZ) begin
        if (accept) begin
            if (cmd.opcode == OP_LD) begin
                dac_word <= LD_WORD;
            end else if (cmd.opcode == OP_WRITE_REG) begin
                dac_word <= cmd.payload[DAC_DATA_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== src/ldac_pulse_gen.sv ====
`timescale 1ns/1ps

module ldac_pulse_gen (
    input  logic       CLK100MHZ,
    input  logic       rst_n,
    input  logic       ldac_start,
    input  logic [7:0] ldac_len,
    output logic       ldac_busy,
    output logic       ldac_n
);

    //////////////////////////////////////////////////////////////////////
    // Pulse timer
    //////////////////////////////////////////////////////////////////////

    // Cycles left after the current one
    // One bit wider than ldac_len since it loads len+1
    logic [8:0] remaining;

    // Strobe low for len+2 cycles
    // Shared by every DAC chip, so the edge is slow and needs the margin
    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            ldac_busy <= 1'b0;
            remaining <= '0;
        end else if (!ldac_busy) begin
            // Start only from idle
            if (ldac_start) begin
                ldac_busy <= 1'b1;
                remaining <= {1'b0, ldac_len} + 9'd1;
            end
        end else if (remaining == '0) begin
            // Last low cycle done
            ldac_busy <= 1'b0;
        end else begin
            remaining <= remaining - 9'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pin
    //////////////////////////////////////////////////////////////////////

    // Low exactly while busy, high out of reset
    assign ldac_n = ~ldac_busy;

endmodule

// ==== src/dac_serial_bank.sv ====
`timescale 1ns/1ps

module dac_serial_bank #(
    parameter int NUM_CHANNELS = 8
) (
    input  logic                                      CLK100MHZ,
    input  logic                                      rst_n,
    input  logic [NUM_CHANNELS-1:0]                   dac_start,
    input  dac_cfg_pkg::dac_word_t                    dac_word,
    output logic [NUM_CHANNELS-1:0]                   dac_busy,
    output dac_cfg_pkg::dac_pins_t [NUM_CHANNELS-1:0] dac_pins
);
    import dac_cfg_pkg::*;

    // Bit counter runs 0..DAC_DATA_WIDTH
    localparam int CNT_W = $clog2(DAC_DATA_WIDTH + 1);

    //////////////////////////////////////////////////////////////////////
    // Per-channel frame shifter
    //////////////////////////////////////////////////////////////////////

    // Frame per channel
    //   cycle 0     cs_n low, sclk low, sdi = bit 23
    //   odd cycles  sclk high, DAC samples sdi
    //   even cycles sclk low, next bit on sdi
    //   after last fall, cs_n back high
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan

        // Word being shifted, MSB is on the pin
        dac_word_t        shreg;
        // Bits already clocked out
        logic [CNT_W-1:0] bit_cnt;
        // Frame in progress, also drives cs_n
        logic             busy_q;
        logic             sclk_q;
        logic             frame_done;

        // All bits sent and sclk back low
        assign frame_done = (bit_cnt == CNT_W'(DAC_DATA_WIDTH));

        always_ff @(posedge CLK100MHZ or negedge rst_n) begin
            if (!rst_n) begin
                busy_q  <= 1'b0;
                sclk_q  <= 1'b0;
                bit_cnt <= '0;
                // Keeps sdi low out of reset
                shreg   <= '0;
            end else if (!busy_q) begin
                // Idle, wait for start
                if (dac_start[i]) begin
                    busy_q  <= 1'b1;
                    sclk_q  <= 1'b0;
                    shreg   <= dac_word;
                    bit_cnt <= '0;
                end
            end else if (frame_done) begin
                // One cycle after the last falling edge
                busy_q <= 1'b0;
            end else if (!sclk_q) begin
                // Rising edge, data already stable
                sclk_q <= 1'b1;
            end else begin
                // Falling edge, move to next bit
                sclk_q  <= 1'b0;
                shreg   <= {shreg[DAC_DATA_WIDTH-2:0], 1'b0};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end

        assign dac_busy[i] = busy_q;

        // Shift register empties to zero, so sdi idles low
        assign dac_pins[i] = '{
            cs_n: ~busy_q,
            sclk: sclk_q,
            sdi:  shreg[DAC_DATA_WIDTH-1]
        };

    end

endmodule

// ==== src/cmd_pkg.sv ====
package cmd_pkg;

    //////////////////////////////////////////////////////////////////////
    // Command side
    //////////////////////////////////////////////////////////////////////

    // Known opcodes
    // Zero and values above OP_SET_LDAC_LEN are unknown commands
    typedef enum logic [3:0] {
        OP_WRITE_REG    = 4'h1,
        OP_LD           = 4'h2,
        OP_LDAC         = 4'h3,
        OP_SET_LDAC_LEN = 4'h4
    } opcode_e;

    // Payload byte count required by WRITE REG
    parameter logic [7:0] WRITE_REG_BYTES = 8'd4;

    // One parsed command
    typedef struct packed {
        // Strobe, one cycle
        logic        valid;
        opcode_e     opcode;
        // Payload byte count as received
        logic [7:0]  length;
        // Mask in [31:24], data word in [23:0]
        // LDAC LENGTH takes its width from [7:0]
        logic [31:0] payload;
    } cmd_t;

    //////////////////////////////////////////////////////////////////////
    // Reply side
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RPL_NONE         = 2'd0,
        RPL_WRONG_LENGTH = 2'd1,
        RPL_UNKNOWN_CMD  = 2'd2
    } reply_code_e;

    // Error reply, valid for one cycle
    typedef struct packed {
        logic        valid;
        reply_code_e code;
        // Received length, or zero for an unknown command
        logic [7:0]  arg;
    } reply_t;

endpackage

// ==== src/dac_cfg_pkg.sv ====
package dac_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // DAC serial word
    //////////////////////////////////////////////////////////////////////

    // Bits shifted out per frame
    parameter int DAC_DATA_WIDTH = 24;

    // Channel select mask, top byte of the command payload
    parameter int MASK_WIDTH = 8;

    // Fixed word sent by LD
    parameter logic [DAC_DATA_WIDTH-1:0] LD_WORD = 24'h004000;

    // LDAC low width setting after reset
    // Low time is this value plus 2 clock cycles
    parameter logic [7:0] LDAC_LEN_DEFAULT = 8'd40;

    // One DAC data word
    typedef logic [DAC_DATA_WIDTH-1:0] dac_word_t;

    //////////////////////////////////////////////////////////////////////
    // Pin bundle
    //////////////////////////////////////////////////////////////////////

    // Serial lines of one DAC chip
    typedef struct packed {
        // Chip select, active low
        logic cs_n;
        // Serial clock, idles low
        logic sclk;
        // Serial data, MSB first
        logic sdi;
    } dac_pins_t;

endpackage
